/* tb.f */
hdl/uart_pkg.sv
hdl/port_pkg.sv
hdl/tx_fifo.sv
hdl/uart_serializer.sv
hdl/uart_tx_chan.sv
hdl/tx_port_regs.sv
hdl/uart_tx_subsys.sv
verif/uart_tx_assert.sv
verif/tb_uart_tx.sv

/* run.sh */
#!/bin/sh
# Builds the transmit block testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_uart_tx -f tb.f -o sim_tb_uart_tx \
  && ./obj_dir/sim_tb_uart_tx \
  || exit 1

/* verif/tb_uart_tx.sv */
// Directed testbench for the three-channel transmit block.
// Drives the outport bus, polls status before each channel write and decodes
// the serial lines against bytes drawn from an LFSR.

`timescale 1ns/1ps

module tb_uart_tx
  import uart_pkg::*, port_pkg::*;
();

  localparam int DRV_DLY   = 1;                                // ns after the rising edge
  localparam int FRAME0    = (1 + DATA_BITS + CH0_STOP) * CH0_DIV;
  localparam int FRAME1    = (1 + DATA_BITS + CH1_STOP) * CH1_DIV;
  localparam int FRAME2    = (1 + DATA_BITS + CH2_STOP) * CH2_DIV;
  localparam int BURST_LEN = 5;
  localparam int FILL_LEN  = FIFO_DEPTH + 1;                   // one in flight plus a full queue
  localparam int RUN_CYCLES  = FRAME2 + BURST_LEN * FRAME0 + FILL_LEN * FRAME1
                             + FRAME0 + FRAME2;
  localparam int CYCLE_LIMIT = 2 * RUN_CYCLES + 2000;
  localparam int ALL_HIGH    = (1 << NUM_CHAN) - 1;

  logic                   i_clk;
  logic                   i_rst;
  port_wr_t               i_port;
  logic [PORT_ADDR_W-1:0] i_status_addr;
  logic [DATA_BITS-1:0]   o_status;
  logic [NUM_CHAN-1:0]    o_uart_tx;
  logic                   o_done;

  logic [31:0] lfsr;
  logic [7:0]  sent_q [$];                                     // bytes written in order
  string       test_name;
  int          cycles;
  int          frames_seen;

  uart_tx_subsys dut (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_port        (i_port),
    .i_status_addr (i_status_addr),
    .o_status      (o_status),
    .o_uart_tx     (o_uart_tx),
    .o_done        (o_done)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run did not finish within %0d cycles, stuck in test %s", CYCLE_LIMIT, test_name);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check(input string what, input int exp, input int act);
    assert (exp == act) else begin
      $display("Error: %s %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1 register stepped once per bit taken
  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      b    = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  function automatic int div_of(input logic [1:0] ch);
    case (ch)
      2'd0:    return CH0_DIV;
      2'd1:    return CH1_DIV;
      default: return CH2_DIV;
    endcase
  endfunction

  function automatic int stop_of(input logic [1:0] ch);
    case (ch)
      2'd0:    return CH0_STOP;
      2'd1:    return CH1_STOP;
      default: return CH2_STOP;
    endcase
  endfunction

  task automatic step(input int n);
    repeat (n) @(posedge i_clk);
    #DRV_DLY;
  endtask

  task automatic read_status(input logic [7:0] addr, output logic [7:0] st);
    i_status_addr = addr;
    #1;                                                        // let the status mux settle
    st = o_status;
  endtask

  task automatic write_port(input logic [7:0] addr, input logic [7:0] data);
    logic [7:0] st;
    read_status(addr, st);
    while (st[0]) begin                                        // wait for room
      step(1);
      read_status(addr, st);
    end
    i_port = '{strobe: 1'b1, addr: addr, data: data};
    step(1);
    i_port.strobe = 1'b0;
  endtask

  // polls each cycle for the start bit and then samples every bit at mid-period
  task automatic decode_frame(input logic [1:0] ch, output logic [7:0] b);
    int div;
    int nstop;
    div   = div_of(ch);
    nstop = stop_of(ch);
    b     = '0;
    while (o_uart_tx[ch] !== 1'b0) step(1);
    step(div / 2);
    assert (o_uart_tx[ch] === 1'b0) else begin
      $display("Start bit on channel %0d did not last to its middle", ch);
      abort_run();
    end
    repeat (DATA_BITS) begin
      step(div);
      b = {o_uart_tx[ch], b[7:1]};                             // lsb arrives first
    end
    repeat (nstop) begin
      step(div);
      assert (o_uart_tx[ch] === 1'b1) else begin
        $display("Missing stop bit on channel %0d in test %s", ch, test_name);
        abort_run();
      end
    end
  endtask

  task automatic expect_frames(input logic [1:0] ch, input int n);
    logic [7:0] got;
    logic [7:0] exp;
    repeat (n) begin
      decode_frame(ch, got);
      exp = sent_q.pop_front();
      check("frame byte", int'(exp), int'(got));
      frames_seen++;
    end
  endtask

  task automatic send_random(input logic [7:0] addr, input int n);
    logic [7:0] b;
    repeat (n) begin
      b = rand_byte();
      sent_q.push_back(b);
      write_port(addr, b);
    end
  endtask

  task automatic check_all_idle();
    logic [7:0] st;
    for (int a = 0; a <= int'(PORT_DONE); a++) begin
      read_status(8'(a), st);
      check($sformatf("status at port %0d", a), 0, int'(st));
    end
  endtask

  task automatic test_reset();
    test_name = "reset";
    step(1);
    check("lines", ALL_HIGH, int'(o_uart_tx));
    check("done", 0, int'(o_done));
    check_all_idle();
  endtask

  task automatic test_direct();
    logic [7:0] b;
    logic [7:0] got;
    logic [7:0] st;
    int         n;
    test_name = "direct";
    b = rand_byte();
    fork
      decode_frame(2'd2, got);
      begin
        write_port(PORT_UART2, b);
        check("line one edge after strobe", 1, int'(o_uart_tx[2]));
        step(1);
        check("line two edges after strobe", 0, int'(o_uart_tx[2]));
        n = 0;
        read_status(PORT_UART2, st);
        while (st[0]) begin
          step(1);
          n++;
          read_status(PORT_UART2, st);
        end
        check("busy cycles", FRAME2, n);
      end
    join
    check("frame byte", int'(b), int'(got));
    read_status(PORT_UART2, st);
    check("status after frame", 0, int'(st));
  endtask

  task automatic test_burst();
    test_name = "burst";
    fork
      expect_frames(2'd0, BURST_LEN);
      send_random(PORT_UART0, BURST_LEN);
    join
  endtask

  task automatic test_fill();
    logic [7:0] st;
    int         waited;
    test_name   = "fifo_fill";
    frames_seen = 0;
    fork
      expect_frames(2'd1, FILL_LEN);
      begin
        send_random(PORT_UART1, FILL_LEN);
        step(2);                                               // full flag lags the writes
        read_status(PORT_UART1, st);
        check("status when full", 1, int'(st[0]));
        wait (frames_seen >= 1);
        waited = 0;
        read_status(PORT_UART1, st);
        while (st[0] && waited < CH1_DIV + 8) begin
          step(1);
          waited++;
          read_status(PORT_UART1, st);
        end
        assert (!st[0]) else begin
          $display("Channel 1 stayed busy after its first frame was sent");
          abort_run();
        end
      end
    join
  endtask

  task automatic test_concurrent();
    logic [7:0] b0;
    logic [7:0] b2;
    logic [7:0] got0;
    logic [7:0] got2;
    logic       done_before;
    test_name = "concurrent";
    b0 = rand_byte();
    b2 = rand_byte();
    fork
      decode_frame(2'd0, got0);
      decode_frame(2'd2, got2);
      begin
        write_port(PORT_UART0, b0);
        write_port(PORT_UART2, b2);
      end
    join
    check("channel 0 byte", int'(b0), int'(got0));
    check("channel 2 byte", int'(b2), int'(got2));
    step(CH2_DIV);                                             // past the last stop bit
    done_before = o_done;
    write_port(8'h5A, rand_byte() | 8'h01);                    // unmapped port
    repeat (2 * CH0_DIV) begin
      step(1);
      check("lines after unmapped write", ALL_HIGH, int'(o_uart_tx));
    end
    check("done after unmapped write", int'(done_before), int'(o_done));
    check_all_idle();
  endtask

  task automatic test_done();
    test_name = "done_flag";
    write_port(PORT_DONE, rand_byte() | 8'h01);
    check("done after set", 1, int'(o_done));
    write_port(PORT_DONE, rand_byte() & 8'hFE);
    check("done after clear", 0, int'(o_done));
  endtask

  initial begin
    lfsr          = 32'h4094;
    cycles        = 0;
    frames_seen   = 0;
    test_name     = "reset";
    i_rst         = 1'b1;
    i_port        = '0;
    i_status_addr = '0;
    repeat (16) @(posedge i_clk);
    #DRV_DLY;
    i_rst = 1'b0;
    test_reset();
    test_direct();
    test_burst();
    test_fill();
    test_concurrent();
    test_done();
    $display("Test passed");
    $finish;
  end

endmodule

/* verif/uart_tx_assert.sv */
// Concurrent checks on the transmit block top level.
// Bound into the top level so it sees the internal request bus.

`timescale 1ns/1ps

module uart_tx_assert
  import uart_pkg::*, port_pkg::*;
(
  input logic                   i_clk,
  input logic                   i_rst,
  input port_wr_t               i_port,
  input tx_req_t [NUM_CHAN-1:0] i_req,
  input logic    [NUM_CHAN-1:0] i_uart_tx,
  input logic                   i_done
);

  logic [NUM_CHAN-1:0] go;                  // request pulses, one per channel
  logic                done_wr;

  always_comb begin
    for (int n = 0; n < NUM_CHAN; n++) begin
      go[n] = i_req[n].go;
    end
  end

  assign done_wr = i_port.strobe && (i_port.addr == PORT_DONE);

  a_one_req: assert property (@(posedge i_clk) disable iff (i_rst) $onehot0(go))
    else $error("more than one channel request pulse in a cycle");

  a_idle_lines: assert property (@(posedge i_clk) $fell(i_rst) |-> (&i_uart_tx))
    else $error("serial line low right after reset");

  a_done_src: assert property (@(posedge i_clk) disable iff (i_rst)
    $changed(i_done) |-> $past(done_wr))
    else $error("done flag changed without a write to its port");

endmodule

bind uart_tx_subsys uart_tx_assert u_assert (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_port    (i_port),
  .i_req     (req),
  .i_uart_tx (o_uart_tx),
  .i_done    (o_done)
);

/* hdl/uart_tx_subsys.sv */
// Top level of the transmit block: the outport decoder and three channels.
// Channels 0 and 1 are buffered; channel 2 is direct with two stop bits.
// Writers poll the status port and write only when the channel is not busy.

`timescale 1ns/1ps

module uart_tx_subsys
  import uart_pkg::*, port_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  port_wr_t               i_port,
  input  logic [PORT_ADDR_W-1:0] i_status_addr,
  output logic [DATA_BITS-1:0]   o_status,
  output logic [NUM_CHAN-1:0]    o_uart_tx,
  output logic                   o_done
);

  tx_req_t [NUM_CHAN-1:0] req;              // per-channel write requests
  logic    [NUM_CHAN-1:0] busy;

  tx_port_regs u_regs (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_port        (i_port),
    .i_status_addr (i_status_addr),
    .i_busy        (busy),
    .o_req         (req),
    .o_done        (o_done),
    .o_status      (o_status)
  );

  uart_tx_chan #(
    .USE_FIFO  (1'b1),
    .DIV       (CH0_DIV),
    .STOP_BITS (CH0_STOP)
  ) u_chan0 (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_req  (req[0]),
    .o_tx   (o_uart_tx[0]),
    .o_busy (busy[0])
  );

  uart_tx_chan #(
    .USE_FIFO  (1'b1),
    .DIV       (CH1_DIV),
    .STOP_BITS (CH1_STOP)
  ) u_chan1 (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_req  (req[1]),
    .o_tx   (o_uart_tx[1]),
    .o_busy (busy[1])
  );

  uart_tx_chan #(
    .USE_FIFO  (1'b0),
    .DIV       (CH2_DIV),
    .STOP_BITS (CH2_STOP)
  ) u_chan2 (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_req  (req[2]),
    .o_tx   (o_uart_tx[2]),
    .o_busy (busy[2])
  );

endmodule

/* hdl/tx_port_regs.sv */
// Outport decoder for the transmit block. Each strobe is decoded into a
// registered request pulse for one channel or an update of the done flag.
// Status reads return the addressed channel's busy bit in bit 0.

`timescale 1ns/1ps

module tx_port_regs
  import uart_pkg::*, port_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  port_wr_t               i_port,
  input  logic [PORT_ADDR_W-1:0] i_status_addr,
  input  logic [NUM_CHAN-1:0]    i_busy,
  output tx_req_t [NUM_CHAN-1:0] o_req,
  output logic                   o_done,
  output logic [DATA_BITS-1:0]   o_status
);

  logic [NUM_CHAN-1:0]  hit;                // channel addressed by this strobe
  logic [NUM_CHAN-1:0]  go_q;               // registered write pulses
  logic [DATA_BITS-1:0] data_q [NUM_CHAN];  // last byte written per channel

  always_comb begin
    hit = '0;
    if (i_port.strobe) begin
      case (i_port.addr)
        PORT_UART0: hit[0] = 1'b1;
        PORT_UART1: hit[1] = 1'b1;
        PORT_UART2: hit[2] = 1'b1;
        default:    hit    = '0;            // done or unmapped
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      go_q <= '0;
    end else begin
      go_q <= hit;                          // one cycle wide by construction
    end
  end

  always_ff @(posedge i_clk) begin
    for (int n = 0; n < NUM_CHAN; n++) begin
      if (hit[n]) begin
        data_q[n] <= i_port.data;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_done <= 1'b0;
    end else if (i_port.strobe && (i_port.addr == PORT_DONE)) begin
      o_done <= i_port.data[0];
    end
  end

  always_comb begin
    for (int n = 0; n < NUM_CHAN; n++) begin
      o_req[n].go   = go_q[n];
      o_req[n].data = data_q[n];
    end
  end

  // status mux, purely combinational
  always_comb begin
    o_status = '0;
    case (i_status_addr)
      PORT_UART0: o_status[0] = i_busy[0];
      PORT_UART1: o_status[0] = i_busy[1];
      PORT_UART2: o_status[0] = i_busy[2];
      default:    o_status    = '0;
    endcase
  end

endmodule

/* hdl/uart_tx_chan.sv */
// One transmit channel. With USE_FIFO set, writes are queued and a launch
// register starts the serializer whenever it is idle; busy is the FIFO full
// flag. Without it, a write launches the serializer directly.

`timescale 1ns/1ps

module uart_tx_chan
  import uart_pkg::*;
#(
  parameter bit USE_FIFO  = 1'b1,
  parameter int DIV       = 8,
  parameter int STOP_BITS = 1
) (
  input  logic    i_clk,
  input  logic    i_rst,
  input  tx_req_t i_req,
  output logic    o_tx,
  output logic    o_busy
);

  tx_req_t ser_req;                         // launch into the serializer
  logic    ser_busy;

  generate
    if (USE_FIFO) begin : g_fifo
      logic                 has_data;
      logic                 full;
      logic                 launch;         // also pops the FIFO
      logic [DATA_BITS-1:0] rdata;

      tx_fifo #(
        .DEPTH (FIFO_DEPTH)
      ) u_fifo (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_wr       (i_req.go),
        .i_wdata    (i_req.data),
        .i_rd       (launch),
        .o_rdata    (rdata),
        .o_has_data (has_data),
        .o_full     (full)
      );

      // the !launch term covers the cycle before busy rises
      always_ff @(posedge i_clk) begin
        if (i_rst) begin
          launch <= 1'b0;
        end else begin
          launch <= has_data && !ser_busy && !launch;
        end
      end

      assign ser_req.go   = launch;
      assign ser_req.data = rdata;
      assign o_busy       = full;
    end else begin : g_direct
      assign ser_req = i_req;
      assign o_busy  = ser_busy;
    end
  endgenerate

  uart_serializer #(
    .DIV       (DIV),
    .STOP_BITS (STOP_BITS)
  ) u_ser (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_req  (ser_req),
    .o_tx   (o_tx),
    .o_busy (ser_busy)
  );

endmodule

/* hdl/uart_serializer.sv */
// Serial transmitter core. A launch request sends one frame: a start bit,
// the data bits lsb first and STOP_BITS stop bits, each DIV clocks long.
// Busy is set by the launch and clears at the end of the last stop bit.

`timescale 1ns/1ps

module uart_serializer
  import uart_pkg::*;
#(
  parameter int DIV       = 8,
  parameter int STOP_BITS = 1
) (
  input  logic    i_clk,
  input  logic    i_rst,
  input  tx_req_t i_req,
  output logic    o_tx,
  output logic    o_busy
);

  localparam int CNT_W = $clog2(DIV);
  localparam int NBITS = DATA_BITS + STOP_BITS;   // bit periods after the start bit
  localparam int NB_W  = $clog2(NBITS + 1);

  localparam logic [CNT_W-1:0] CNT_LOAD  = CNT_W'(DIV - 1);
  localparam logic [NB_W-1:0]  NB_LOAD   = NB_W'(NBITS);

  logic [CNT_W-1:0]     cnt;                // clocks left in this bit
  logic                 tick;               // bit period boundary
  logic [DATA_BITS-1:0] sreg;               // bits still to go out
  logic [NB_W-1:0]      nleft;              // bit periods left after this one

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (i_req.go || tick) begin
      cnt  <= CNT_LOAD;
      tick <= 1'b0;
    end else if (o_busy) begin
      cnt  <= cnt - 1'b1;
      tick <= (cnt == CNT_W'(1));           // lands on the last clock of the bit
    end
  end

  // ones shift in behind the data and become the stop bits
  always_ff @(posedge i_clk) begin
    if (i_req.go) begin
      sreg <= i_req.data;
    end else if (tick) begin
      sreg <= {1'b1, sreg[DATA_BITS-1:1]};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_tx <= 1'b1;                         // idle line is high
    end else if (i_req.go) begin
      o_tx <= 1'b0;                         // start bit
    end else if (tick) begin
      o_tx <= sreg[0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      nleft <= '0;
    end else if (i_req.go) begin
      nleft <= NB_LOAD;
    end else if (tick && (nleft != '0)) begin
      nleft <= nleft - 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_busy <= 1'b0;
    end else if (i_req.go) begin
      o_busy <= 1'b1;
    end else if (tick && (nleft == '0)) begin
      o_busy <= 1'b0;                       // end of the last stop bit
    end
  end

endmodule

/* hdl/tx_fifo.sv */
// Byte FIFO placed in front of a serializer.
// Pointers carry one wrap bit. The has-data and full flags are registered and
// the read word is fetched every cycle, so it is ready when a pop is issued.

`timescale 1ns/1ps

module tx_fifo #(
  parameter int DEPTH = 8
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_wr,
  input  logic [7:0] i_wdata,
  input  logic       i_rd,
  output logic [7:0] o_rdata,
  output logic       o_has_data,
  output logic       o_full
);

  localparam int AW = $clog2(DEPTH);

  logic [7:0]  mem [DEPTH];
  logic [AW:0] wr_ptr;                      // msb is the wrap bit
  logic [AW:0] rd_ptr;

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      mem[wr_ptr[AW-1:0]] <= i_wdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // flags lag the pointers by one cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_has_data <= 1'b0;
      o_full     <= 1'b0;
    end else begin
      o_has_data <= (wr_ptr != rd_ptr);
      o_full     <= (rd_ptr == (wr_ptr ^ {1'b1, {AW{1'b0}}}));   // differ in wrap bit only
    end
  end

  always_ff @(posedge i_clk) begin
    o_rdata <= mem[rd_ptr[AW-1:0]];         // head of queue, read ahead
  end

endmodule

/* hdl/port_pkg.sv */
// Port address map and outport write bus of the transmit block.
// A writer drives one strobe cycle per byte and polls status before writing.

package port_pkg;

  localparam int PORT_ADDR_W = 8;           // port address width

  // write addresses; status reads use the same channel addresses
  localparam logic [PORT_ADDR_W-1:0] PORT_UART0 = 8'd0;
  localparam logic [PORT_ADDR_W-1:0] PORT_UART1 = 8'd1;
  localparam logic [PORT_ADDR_W-1:0] PORT_UART2 = 8'd2;
  localparam logic [PORT_ADDR_W-1:0] PORT_DONE  = 8'd3;   // bit 0 drives the done flag

  // outport bus, one word per write cycle
  typedef struct packed {
    logic                   strobe;         // single-cycle write
    logic [PORT_ADDR_W-1:0] addr;           // target port
    logic [7:0]             data;           // write byte
  } port_wr_t;

endpackage

/* hdl/uart_pkg.sv */
// Frame and channel constants for the three-channel serial transmit block.
// Imported by the transmit channel modules, the port decoder and the testbench.
// Divisors are kept small so whole frames fit in short simulations.

package uart_pkg;

  // frame shape
  localparam int DATA_BITS = 8;             // data bits per frame, lsb first
  localparam int NUM_CHAN  = 3;             // transmit channels

  // clocks per bit, one per channel
  localparam int CH0_DIV   = 8;
  localparam int CH1_DIV   = 12;
  localparam int CH2_DIV   = 10;

  // stop bits per channel
  localparam int CH0_STOP  = 1;
  localparam int CH1_STOP  = 1;
  localparam int CH2_STOP  = 2;

  // byte queue in front of the buffered channels
  localparam int FIFO_DEPTH = 8;            // power of two

  // Launch request into a serializer. The go bit is a one-cycle pulse and the
  // data field must be valid in the same cycle.
  typedef struct packed {
    logic                 go;               // start a frame
    logic [DATA_BITS-1:0] data;             // byte to send
  } tx_req_t;

endpackage
